// ==== Makefile ====
# Verilator build and run for the data cache memory system
TOP = mem_system_tb
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --assert -j 0 --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	verilator --lint-only --timing --top-module $(TOP) -f compile.f
	verilator --lint-only +incdir+source --top-module mem_system \
		source/mem_types_pkg.sv source/ctrl_types_pkg.sv source/mem_bus_if.sv \
		source/direct_cache.sv source/banked_mem.sv source/cache_ctrl.sv \
		source/mem_system.sv

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
+incdir+source
source/mem_types_pkg.sv
source/ctrl_types_pkg.sv
source/mem_bus_if.sv
source/direct_cache.sv
source/banked_mem.sv
source/cache_ctrl.sv
source/mem_system.sv
verif/mem_system_tb.sv

// ==== source/banked_mem.sv ====
// Four-bank main memory
// Word address bits [2:1] pick the bank, so a line spans all four banks
// Reads pass a two-stage pipeline, writes land at the clock edge
`timescale 1ns/1ps
`include "mem_macros.svh"

module banked_mem import mem_types_pkg::*; (
   input logic    clk,
   mem_bus_if.mem bus
);

   // Row within a bank, above the bank and byte bits
   localparam int ROW_W = `ADDR_W - `OFFSET_W - 1;
   localparam int ROWS  = 1 << ROW_W;

   offset_t          bank_sel;
   logic [ROW_W-1:0] row;

   // Stage 1 holds the read address
   logic             s1_valid;
   offset_t          s1_bank;
   logic [ROW_W-1:0] s1_row;

   // Stage 2 holds the read data
   logic             s2_valid;
   data_t            s2_data;

   data_t bank_word [`LINE_WORDS];

   assign bank_sel = bus.mem_addr[`OFFSET_W:1];
   assign row      = bus.mem_addr[`ADDR_W-1 -: ROW_W];

   for (genvar b = 0; b < `LINE_WORDS; b++) begin : g_bank
      data_t cells [ROWS];

      // Contents start at zero
      initial begin
         for (int i = 0; i < ROWS; i++) begin
            cells[i] = '0;
         end
      end

      always @(posedge clk) begin
         if (bus.mem_wr && (bank_sel == offset_t'(b))) begin
            cells[row] <= bus.mem_wdata;
         end
      end

      assign bank_word[b] = cells[s1_row];
   end

   // Address, data and valid move one stage per clock
   always_ff @(posedge clk) begin
      s1_valid <= bus.mem_rd;
      s1_bank  <= bank_sel;
      s1_row   <= row;
      s2_valid <= s1_valid;
      s2_data  <= bank_word[s1_bank];
   end

   assign bus.mem_rdata  = s2_data;
   assign bus.mem_rvalid = s2_valid;

   // A bank stays busy for the whole read latency
   a_bank_free: assert property (@(posedge clk)
      bus.mem_rd |-> !($past(bus.mem_rd, `MEM_LATENCY-1) &&
                       ($past(bank_sel, `MEM_LATENCY-1) == bank_sel)));

endmodule

// ==== source/cache_ctrl.sv ====
// Cache controller
// Latches one word request and flags bad requests
// On a miss writes back a dirty victim, fills the line and retries
`timescale 1ns/1ps
`include "mem_macros.svh"

module cache_ctrl import mem_types_pkg::*, ctrl_types_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  addr_t   addr,
   input  data_t   data_in,
   input  logic    rd,
   input  logic    wr,
   output data_t   data_out,
   output logic    done,
   output logic    stall,
   output logic    cache_hit,
   output logic    err,
   output logic    enable,
   output logic    comp,
   output logic    write,
   output logic    valid_in,
   output index_t  index,
   output tag_t    tag_in,
   output offset_t offset,
   output data_t   wdata,
   input  logic    hit,
   input  logic    dirty,
   input  tag_t    tag_out,
   input  data_t   rdata,
   mem_bus_if.ctrl bus
);

   ctrl_state_t state;
   ctrl_state_t next_state;

   // Request held for the whole miss
   addr_t   req_addr;
   data_t   req_data;
   access_t req_kind;
   logic    req_err;
   logic    accept;

   index_t  req_index;
   tag_t    req_tag;
   offset_t req_offset;
   logic    acc_write;

   // Issue counter for write-back words and fill reads
   logic [`OFFSET_W:0] issue_cnt;
   // Install counter for returning fill words
   logic [`OFFSET_W:0] fill_cnt;

   logic  first_hit;
   data_t rdata_q;

   assign accept     = (state == IDLE) && (rd || wr);
   assign req_index  = req_addr[`ADDR_W-1 -: `INDEX_W];
   assign req_tag    = req_addr[`TAG_W+`OFFSET_W -: `TAG_W];
   assign req_offset = req_addr[`OFFSET_W:1];
   assign acc_write  = (req_kind == ACC_WRITE);

   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data_in;
         req_kind <= wr ? ACC_WRITE : ACC_READ;
      end
      // Read data captured on the hit that answers the request
      if ((state == LOOKUP || state == RETRY) && hit) begin
         rdata_q <= rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= IDLE;
         req_err   <= 1'b0;
         first_hit <= 1'b0;
         issue_cnt <= '0;
         fill_cnt  <= '0;
      end else begin
         state <= next_state;
         // Odd address or read with write
         if (accept) begin
            req_err <= addr[0] || (rd && wr);
         end
         // Only the first lookup decides cache_hit
         if (state == LOOKUP) begin
            first_hit <= hit;
         end
         case (state)
            WRITEBACK: begin
               if (issue_cnt == `LINE_WORDS-1) begin
                  issue_cnt <= '0;
               end else begin
                  issue_cnt <= issue_cnt + 1'b1;
               end
            end
            FILL: begin
               if (issue_cnt != `LINE_WORDS) begin
                  issue_cnt <= issue_cnt + 1'b1;
               end
            end
            default: issue_cnt <= '0;
         endcase
         if (state != FILL) begin
            fill_cnt <= '0;
         end else if (bus.mem_rvalid) begin
            fill_cnt <= fill_cnt + 1'b1;
         end
      end
   end

   always_comb begin
      next_state    = state;
      enable        = 1'b0;
      comp          = 1'b0;
      write         = 1'b0;
      valid_in      = 1'b0;
      index         = req_index;
      tag_in        = req_tag;
      offset        = req_offset;
      wdata         = req_data;
      bus.mem_addr  = {req_index, req_tag, issue_cnt[`OFFSET_W-1:0], 1'b0};
      bus.mem_wdata = rdata;
      bus.mem_wr    = 1'b0;
      bus.mem_rd    = 1'b0;
      case (state)
         IDLE: begin
            if (rd || wr) begin
               next_state = LOOKUP;
            end
         end
         LOOKUP: begin
            // Bad requests leave the cache alone
            enable = !req_err;
            comp   = 1'b1;
            write  = acc_write && hit;
            if (req_err || hit) begin
               next_state = RESPOND;
            end else if (dirty) begin
               next_state = WRITEBACK;
            end else begin
               next_state = FILL;
            end
         end
         WRITEBACK: begin
            // Victim word goes back under its old tag
            enable       = 1'b1;
            offset       = issue_cnt[`OFFSET_W-1:0];
            bus.mem_addr = {req_index, tag_out, issue_cnt[`OFFSET_W-1:0], 1'b0};
            bus.mem_wr   = 1'b1;
            if (issue_cnt == `LINE_WORDS-1) begin
               next_state = FILL;
            end
         end
         FILL: begin
            // One read per cycle, one bank each
            bus.mem_rd = (issue_cnt != `LINE_WORDS);
            enable     = bus.mem_rvalid;
            write      = bus.mem_rvalid;
            valid_in   = 1'b1;
            offset     = fill_cnt[`OFFSET_W-1:0];
            wdata      = bus.mem_rdata;
            if (fill_cnt == `LINE_WORDS) begin
               next_state = RETRY;
            end
         end
         RETRY: begin
            enable     = 1'b1;
            comp       = 1'b1;
            write      = acc_write && hit;
            next_state = RESPOND;
         end
         default: next_state = IDLE;
      endcase
   end

   assign stall     = (state != IDLE);
   assign done      = (state == RESPOND);
   assign cache_hit = done && first_hit;
   assign err       = done && req_err;
   assign data_out  = rdata_q;

   // Done only answers a request taken earlier
   a_done_latched: assert property (@(posedge clk) disable iff (rst)
      done |-> $past(stall) && !$past(done));

   a_stall_bound: assert property (@(posedge clk) disable iff (rst)
      $rose(stall) |-> ##[1:`MISS_TIMEOUT] !stall);

   a_bus_excl: assert property (@(posedge clk) disable iff (rst)
      !(bus.mem_rd && bus.mem_wr));

endmodule

// ==== source/ctrl_types_pkg.sv ====
// Cache controller types
// FSM states and the kind of access held across a miss
package ctrl_types_pkg;

   // Miss handling sequence
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      WRITEBACK,
      FILL,
      RETRY,
      RESPOND
   } ctrl_state_t;

   // Latched request kind
   typedef enum logic {
      ACC_READ,
      ACC_WRITE
   } access_t;

endpackage

// ==== source/direct_cache.sv ====
// Direct-mapped cache arrays
// 256 lines of four words with tag, valid and dirty bits
// Compare mode checks the tag, fill mode writes a line word directly
`timescale 1ns/1ps
`include "mem_macros.svh"

module direct_cache import mem_types_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    enable,
   input  logic    comp,
   input  logic    write,
   input  logic    valid_in,
   input  index_t  index,
   input  tag_t    tag_in,
   input  offset_t offset,
   input  data_t   wdata,
   output logic    hit,
   output logic    dirty,
   output tag_t    tag_out,
   output data_t   rdata
);

   localparam int LINES = 1 << `INDEX_W;

   tag_t  tags  [LINES];
   data_t words [LINES][`LINE_WORDS];

   logic [LINES-1:0] valid_bits;
   logic [LINES-1:0] dirty_bits;

   logic line_valid;
   logic do_write;

   assign line_valid = valid_bits[index];

   // Tag compare only counts in compare mode
   assign hit = enable && comp && line_valid && (tags[index] == tag_in);

   // Dirty only means something on a valid line
   assign dirty   = line_valid && dirty_bits[index];
   assign tag_out = tags[index];
   assign rdata   = words[index][offset];

   // Compare writes need a hit, fill writes always land
   assign do_write = enable && write && (!comp || hit);

   always_ff @(posedge clk) begin
      if (do_write) begin
         words[index][offset] <= wdata;
         // Fill also installs the new tag
         if (!comp) begin
            tags[index] <= tag_in;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (do_write) begin
         if (comp) begin
            // Store hit marks the line modified
            dirty_bits[index] <= 1'b1;
         end else begin
            valid_bits[index] <= valid_in;
            dirty_bits[index] <= 1'b0;
         end
      end
   end

   // Controller must only store on a compare hit
   a_comp_write_hit: assert property (@(posedge clk) disable iff (rst)
      (enable && comp && write) |-> hit);

endmodule

// ==== source/mem_bus_if.sv ====
// Controller to memory bus
// Address, write data and strobes toward the banks, read data and
// its valid flag back to the controller
`timescale 1ns/1ps

interface mem_bus_if import mem_types_pkg::*; ();

   addr_t mem_addr;
   data_t mem_wdata;
   logic  mem_wr;
   logic  mem_rd;

   // Returned MEM_LATENCY cycles after mem_rd
   data_t mem_rdata;
   logic  mem_rvalid;

   modport ctrl (
      output mem_addr, mem_wdata, mem_wr, mem_rd,
      input  mem_rdata, mem_rvalid
   );

   modport mem (
      input  mem_addr, mem_wdata, mem_wr, mem_rd,
      output mem_rdata, mem_rvalid
   );

endinterface

// ==== source/mem_macros.svh ====
// Memory system sizes
// Address and data widths, cache geometry, memory latency and the
// cycle bound used by the controller checks
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Byte address and data word
`define ADDR_W 16
`define DATA_W 16

// Address split: index [15:8], tag [7:3], word offset [2:1], byte [0]
`define TAG_W 5
`define INDEX_W 8
`define OFFSET_W 2
`define LINE_WORDS 4

// Pipelined read latency of the banked memory
`define MEM_LATENCY 2

// Longest stall allowed for one request
`define MISS_TIMEOUT 32

`endif

// ==== source/mem_system.sv ====
// Data cache memory system
// Controller, direct-mapped cache and four-bank memory
// Word requests with a stall and done handshake
`timescale 1ns/1ps

module mem_system import mem_types_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  addr_t addr,
   input  data_t data_in,
   input  logic  rd,
   input  logic  wr,
   output data_t data_out,
   output logic  done,
   output logic  stall,
   output logic  cache_hit,
   output logic  err
);

   // Controller to cache
   logic    c_enable;
   logic    c_comp;
   logic    c_write;
   logic    c_valid_in;
   index_t  c_index;
   tag_t    c_tag_in;
   offset_t c_offset;
   data_t   c_wdata;

   // Cache to controller
   logic    c_hit;
   logic    c_dirty;
   tag_t    c_tag_out;
   data_t   c_rdata;

   mem_bus_if mem_bus ();

   cache_ctrl u_ctrl (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err),
      .enable    (c_enable),
      .comp      (c_comp),
      .write     (c_write),
      .valid_in  (c_valid_in),
      .index     (c_index),
      .tag_in    (c_tag_in),
      .offset    (c_offset),
      .wdata     (c_wdata),
      .hit       (c_hit),
      .dirty     (c_dirty),
      .tag_out   (c_tag_out),
      .rdata     (c_rdata),
      .bus       (mem_bus.ctrl)
   );

   direct_cache u_cache (
      .clk      (clk),
      .rst      (rst),
      .enable   (c_enable),
      .comp     (c_comp),
      .write    (c_write),
      .valid_in (c_valid_in),
      .index    (c_index),
      .tag_in   (c_tag_in),
      .offset   (c_offset),
      .wdata    (c_wdata),
      .hit      (c_hit),
      .dirty    (c_dirty),
      .tag_out  (c_tag_out),
      .rdata    (c_rdata)
   );

   banked_mem u_mem (
      .clk (clk),
      .bus (mem_bus.mem)
   );

endmodule

// ==== source/mem_types_pkg.sv ====
// Memory system data types
// Vector types for addresses, data words and the cache address fields
`include "mem_macros.svh"

package mem_types_pkg;

   // Byte address into main memory
   typedef logic [`ADDR_W-1:0] addr_t;

   // One data word
   typedef logic [`DATA_W-1:0] data_t;

   // Line tag kept beside each cache line
   typedef logic [`TAG_W-1:0] tag_t;

   // Cache line number
   typedef logic [`INDEX_W-1:0] index_t;

   // Word within a line, also the memory bank number
   typedef logic [`OFFSET_W-1:0] offset_t;

endpackage

// ==== verif/mem_system_tb.sv ====
// Testbench for the data cache memory system
// Replays file vectors checked against a shadow model of memory and
// line tags, then a random phase in a three-line window
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_system_tb import mem_types_pkg::*; ();

   localparam int WORDS        = 1 << (`ADDR_W - 1);
   localparam int LINES        = 1 << `INDEX_W;
   localparam int RESET_CYCLES = 8;
   localparam int DONE_TIMEOUT = 64;
   localparam int HIT_CYCLES   = 2;
   localparam int RANDOM_OPS   = 80;
   // Three lines at index 0x56, tags 0 to 2
   localparam addr_t RANDOM_BASE = 16'h5600;

   logic  clk;
   logic  rst;
   addr_t addr;
   data_t data_in;
   logic  rd;
   logic  wr;
   data_t data_out;
   logic  done;
   logic  stall;
   logic  cache_hit;
   logic  err;

   // Shadow of memory contents and of the line each index holds
   data_t shadow_mem   [WORDS];
   tag_t  shadow_tag   [LINES];
   logic  shadow_valid [LINES];

   integer seed;
   int     vec_count;

   mem_system uut (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   task automatic abort_run();
      $display("=== FAIL ===");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("Fail at time %0t: %s got %h expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail at time %0t: %s got %b expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("Fail at time %0t: %s got %0d expected %0d", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic clear_shadow();
      for (int i = 0; i < WORDS; i++) begin
         shadow_mem[i] = '0;
      end
      for (int i = 0; i < LINES; i++) begin
         shadow_tag[i]   = '0;
         shadow_valid[i] = 1'b0;
      end
   endtask

   // Expected response, then the model takes the access
   task automatic model_access(input logic do_rd, input logic do_wr, input addr_t a,
                               input data_t d, output data_t exp_data,
                               output logic exp_hit, output logic exp_err);
      index_t              idx;
      tag_t                tag;
      logic [`ADDR_W-2:0]  word;
      idx      = a[`ADDR_W-1 -: `INDEX_W];
      tag      = a[`TAG_W+`OFFSET_W -: `TAG_W];
      word     = a[`ADDR_W-1:1];
      exp_err  = a[0] || (do_rd && do_wr);
      exp_hit  = 1'b0;
      exp_data = '0;
      if (!exp_err) begin
         exp_hit  = shadow_valid[idx] && (shadow_tag[idx] == tag);
         exp_data = shadow_mem[word];
         if (do_wr) begin
            shadow_mem[word] = d;
         end
         shadow_valid[idx] = 1'b1;
         shadow_tag[idx]   = tag;
      end
   endtask

   // Starts on a falling edge with the system idle, ends one cycle after done
   task automatic run_request(input logic do_rd, input logic do_wr, input addr_t a,
                              input data_t d, output data_t got_data,
                              output logic got_hit, output logic got_err,
                              output int cycles);
      int n;
      addr    = a;
      data_in = d;
      rd      = do_rd;
      wr      = do_wr;
      n       = 0;
      do begin
         @(negedge clk);
         rd = 1'b0;
         wr = 1'b0;
         n  = n + 1;
         if (n == 1) begin
            check_flag("stall", stall, 1'b1);
         end
         if (n > DONE_TIMEOUT) begin
            $display("Timeout: no done within %0d cycles of the request", DONE_TIMEOUT);
            abort_run();
         end
      end while (done !== 1'b1);
      got_data = data_out;
      got_hit  = cache_hit;
      got_err  = err;
      cycles   = n;
      @(negedge clk);
      check_flag("stall", stall, 1'b0);
      check_flag("done", done, 1'b0);
   endtask

   task automatic check_response(input logic is_read, input data_t exp_data,
                                 input logic exp_hit, input logic exp_err,
                                 input data_t got_data, input logic got_hit,
                                 input logic got_err, input int cycles);
      check_flag("err", got_err, exp_err);
      check_flag("cache_hit", got_hit, exp_hit);
      if (is_read && !exp_err) begin
         check_data("data_out", got_data, exp_data);
      end
      // Hits and bad requests answer after LOOKUP only
      if (exp_hit || exp_err) begin
         check_count("done latency", cycles, HIT_CYCLES);
      end
   endtask

   task automatic run_vectors();
      int          fd;
      int          fields;
      int          cycles;
      string       line;
      logic [31:0] op;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] ed;
      logic [31:0] eh;
      logic [31:0] ee;
      logic        do_rd;
      logic        do_wr;
      data_t       m_data;
      logic        m_hit;
      logic        m_err;
      data_t       got_data;
      logic        got_hit;
      logic        got_err;
      fd = $fopen("verif/mem_tests.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the test vector file verif/mem_tests.txt");
         abort_run();
      end
      while ($fgets(line, fd) > 0) begin
         if (line.getc(0) != "#") begin
            fields = $sscanf(line, "%h %h %h %h %h %h", op, a, d, ed, eh, ee);
            if (fields == 6) begin
               vec_count = vec_count + 1;
               do_rd = (op == 32'd0) || (op == 32'd2);
               do_wr = (op == 32'd1) || (op == 32'd2);
               model_access(do_rd, do_wr, a[`ADDR_W-1:0], d[`DATA_W-1:0],
                            m_data, m_hit, m_err);
               // File and shadow model must tell the same story
               if ((eh[0] !== m_hit) || (ee[0] !== m_err) ||
                   (do_rd && !m_err && (ed[`DATA_W-1:0] !== m_data))) begin
                  $display("Test vector %0d disagrees with the shadow model", vec_count);
                  abort_run();
               end
               run_request(do_rd, do_wr, a[`ADDR_W-1:0], d[`DATA_W-1:0],
                           got_data, got_hit, got_err, cycles);
               check_response(!do_wr, ed[`DATA_W-1:0], eh[0], ee[0],
                              got_data, got_hit, got_err, cycles);
            end else if (fields > 0) begin
               $display("Malformed test vector line after vector %0d", vec_count);
               abort_run();
            end
         end
      end
      $fclose(fd);
      if (vec_count == 0) begin
         $display("No test vectors were read");
         abort_run();
      end
   endtask

   task automatic run_random();
      int          cycles;
      logic [31:0] r;
      logic [3:0]  word_sel;
      logic        do_wr;
      addr_t       a;
      data_t       d;
      data_t       m_data;
      logic        m_hit;
      logic        m_err;
      data_t       got_data;
      logic        got_hit;
      logic        got_err;
      seed = 32'h7865_b9f0;
      for (int i = 0; i < RANDOM_OPS; i++) begin
         r        = $random(seed);
         word_sel = 4'(r[7:0] % 8'd12);
         a        = RANDOM_BASE + {11'b0, word_sel, 1'b0};
         do_wr    = r[8];
         d        = r[31:16];
         model_access(!do_wr, do_wr, a, d, m_data, m_hit, m_err);
         run_request(!do_wr, do_wr, a, d, got_data, got_hit, got_err, cycles);
         check_response(!do_wr, m_data, m_hit, m_err, got_data, got_hit, got_err, cycles);
      end
   endtask

   initial begin
      rst       = 1'b1;
      addr      = '0;
      data_in   = '0;
      rd        = 1'b0;
      wr        = 1'b0;
      vec_count = 0;
      clear_shadow();
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check_flag("done", done, 1'b0);
      check_flag("stall", stall, 1'b0);
      check_flag("err", err, 1'b0);
      check_flag("cache_hit", cache_hit, 1'b0);
      run_vectors();
      run_random();
      $display("Checked %0d vectors and %0d random accesses", vec_count, RANDOM_OPS);
      $display("=== PASS ===");
      $finish;
   end

endmodule

// ==== verif/mem_tests.txt ====
# op (0 read, 1 write, 2 read and write) addr wdata exp_data exp_hit exp_err
# exp_data only counts for reads without error
0 1218 0000 0000 0 0
0 1218 0000 0000 1 0
1 121A BEEF 0000 1 0
0 1218 0000 0000 1 0
0 121A 0000 BEEF 1 0
0 121C 0000 0000 1 0
0 121E 0000 0000 1 0
1 342C CAFE 0000 0 0
0 3428 0000 0000 1 0
0 342A 0000 0000 1 0
0 342C 0000 CAFE 1 0
0 342E 0000 0000 1 0
0 1250 0000 0000 0 0
0 121A 0000 BEEF 0 0
0 121A 0000 BEEF 1 0
1 1252 1234 0000 0 0
0 1218 0000 0000 0 0
0 1252 0000 1234 0 0
0 1219 0000 0000 0 1
0 1252 0000 1234 1 0
2 1252 FFFF 0000 0 1
0 1252 0000 1234 1 0
1 3429 5555 0000 0 1
0 342A 0000 0000 1 0
